/* bus_cond_gen.sv */
module bus_cond_gen import eeprom_bus_pkg::*;
(
    input  logic       CLK,
    input  logic       RESET,
    input  bit_phase_t phase,
    input  logic       cond_go,
    input  logic       cond_stop,
    output logic       cond_done,
    output logic       cond_pull
);

    typedef enum logic [1:0] {c_idle, c_lead, c_trail} cond_state_t;

    cond_state_t state;
    logic        is_stop;

    assign cond_done = (state == c_trail) && phase.tick && (phase.phase == 2'd3);

    always_ff @(posedge CLK)
    begin
        if (RESET)
        begin
            state     <= c_idle;
            cond_pull <= 1'b0;
        end
        else if (cond_go)
        begin
            state     <= c_lead;
            cond_pull <= cond_stop;  // stop begins low
        end
        else if ((state == c_lead) && phase.tick && (phase.phase == 2'd1))
        begin
            // sda edge in phase 2 while scl is high
            state     <= c_trail;
            cond_pull <= ~is_stop;
        end
        else if (cond_done)
        begin
            state     <= c_idle;
            cond_pull <= 1'b0;
        end
    end

    always_ff @(posedge CLK)
    begin
        if (cond_go)
            is_stop <= cond_stop;
    end

    a_pull_on_tick: assert property (@(posedge CLK) disable iff (RESET)
        $changed(cond_pull) |-> $past(phase.tick));

endmodule

/* byte_rx.sv */
module byte_rx import eeprom_bus_pkg::*;
(
    input  logic       CLK,
    input  logic       RESET,
    input  bit_phase_t phase,
    input  logic       rx_go,
    input  logic       sda_in,
    output logic       rx_done,
    output logic [7:0] rx_byte,
    output logic       rx_pull
);

    logic [7:0] shreg;
    logic [3:0] slot;
    logic       busy;
    logic       slot_end;

    assign slot_end = busy && phase.tick && (phase.phase == 2'd3);
    assign rx_done  = slot_end && (slot == 4'd8);
    assign rx_byte  = shreg;

    // single byte read ends with a master nak
    // so sda stays released in slot 9
    assign rx_pull = 1'b0;

    always_ff @(posedge CLK)
    begin
        if (RESET)
        begin
            busy <= 1'b0;
            slot <= 4'd0;
        end
        else if (rx_go)
        begin
            busy <= 1'b1;
            slot <= 4'd0;
        end
        else if (slot_end)
        begin
            if (slot == 4'd8)
                busy <= 1'b0;
            else
                slot <= slot + 4'd1;
        end
    end

    always_ff @(posedge CLK)
    begin
        // sample late in phase 2 while scl is high
        if (busy && phase.tick && (phase.phase == 2'd2) && (slot < 4'd8))
            shreg <= {shreg[6:0], sda_in};
    end

endmodule

/* byte_tx.sv */
module byte_tx import eeprom_bus_pkg::*;
(
    input  logic       CLK,
    input  logic       RESET,
    input  bit_phase_t phase,
    input  logic       tx_go,
    input  ctrl_byte_u tx_byte,
    input  logic       sda_in,
    output logic       tx_done,
    output logic       tx_nak,
    output logic       tx_pull
);

    ctrl_byte_u shreg;
    logic [3:0] slot;      // 0..7 data, 8 ack
    logic       busy;
    logic       slot_end;

    assign slot_end = busy && phase.tick && (phase.phase == 2'd3);
    assign tx_done  = slot_end && (slot == 4'd8);

    always_ff @(posedge CLK)
    begin
        if (RESET)
        begin
            busy    <= 1'b0;
            slot    <= 4'd0;
            tx_pull <= 1'b0;
            tx_nak  <= 1'b0;
        end
        else if (tx_go)
        begin
            busy    <= 1'b1;
            slot    <= 4'd0;
            tx_pull <= ~tx_byte.raw[7];  // msb first
            tx_nak  <= 1'b0;
        end
        else if (slot_end)
        begin
            if (slot == 4'd8)
                busy <= 1'b0;
            else
                slot <= slot + 4'd1;
            // next bit, or let go of sda for the ack slot
            tx_pull <= (slot < 4'd7) ? ~shreg.raw[6] : 1'b0;
        end
        else if (busy && phase.tick && (phase.phase == 2'd2) && (slot == 4'd8))
            tx_nak <= sda_in;  // released line means no ack
    end

    always_ff @(posedge CLK)
    begin
        if (tx_go)
            shreg <= tx_byte;
        else if (slot_end)
            shreg.raw <= {shreg.raw[6:0], 1'b0};
    end

    // data must never move while scl is high
    a_pull_at_phase0: assert property (@(posedge CLK) disable iff (RESET)
        $changed(tx_pull) |-> $past(phase.tick && (phase.phase == 2'd3)));

endmodule

/* eeprom_bus_pkg.sv */
package eeprom_bus_pkg;

    // 24Cxx device type code in the control byte
    localparam logic [3:0] DEV_CODE = 4'b1010;

    // bit slot timing
    // four phases per slot, scl high in phases 1 and 2
    // sda only moves when stepping into phase 0
    typedef struct packed {
        logic       tick;   // last cycle of the current phase
        logic [1:0] phase;
    } bit_phase_t;

    // control byte seen as fields or as a plain shift byte
    typedef union packed {
        logic [7:0] raw;
        struct packed {
            logic [3:0] dev_code;
            logic [2:0] block;  // addr[10:8]
            logic       rnw;    // 1 for read
        } f;
    } ctrl_byte_u;

endpackage

/* eeprom_host_pkg.sv */
package eeprom_host_pkg;

    // host request levels, held until ack
    typedef struct packed {
        logic        wr;
        logic        rd;
        logic [10:0] addr;  // bits 10:8 pick the 256-byte block
    } host_req_t;

    typedef struct packed {
        logic       ack;    // one cycle at the end of a transaction
        logic       nak;    // only seen together with ack
        logic [7:0] rdata;
    } host_rsp_t;

    // transaction sequencer states
    typedef enum logic [3:0] {
        idle,
        ready,
        wr_start,
        ctrl_wr,
        addr_wr,
        data_wr,
        rd_start,
        ctrl_rd,
        data_rd,
        stop,
        done
    } seq_state_t;

endpackage

/* eeprom_model.sv */
module eeprom_model import eeprom_bus_pkg::*;
(
    input  logic scl,
    inout  wire  sda,
    input  logic absent     // high makes the device ignore every byte
);

    timeunit 1ns;
    timeprecision 1ps;

    logic [7:0]  mem [0:2047];
    ctrl_byte_u  ctrl;
    logic [10:0] ptr;
    logic [7:0]  shreg;
    logic [7:0]  txd;
    int          bit_cnt;     // scl rising edges in the current byte, 9 with ack
    int          byte_idx;
    logic        active;
    logic        sending;
    logic        acked;
    logic        master_nak;
    logic        pull;
    logic        scl_q;
    logic        sda_q;

    assign sda = pull ? 1'b0 : 1'bz;

    initial
    begin
        for (int a = 0; a < 2048; a++)
            mem[a] = 8'(a) ^ {a[10:8], 5'b10110};
        active     = 1'b0;
        sending    = 1'b0;
        acked      = 1'b0;
        master_nak = 1'b0;
        pull       = 1'b0;
        bit_cnt    = 0;
        byte_idx   = 0;
        scl_q      = 1'b1;
        sda_q      = 1'b1;
    end

    task automatic take_byte();
        acked = 1'b1;
        case (byte_idx)
            0:
            begin
                ctrl.raw  = shreg;
                acked     = (ctrl.f.dev_code == DEV_CODE) && !absent;
                ptr[10:8] = ctrl.f.block;
            end
            1:
                ptr[7:0] = shreg;
            default:
                mem[ptr] = shreg;
        endcase
        pull = acked;   // ack slot
    endtask

    task automatic on_rise();
        if (bit_cnt < 8 && !sending)
            shreg = {shreg[6:0], sda};
        else if (bit_cnt == 8 && sending)
            master_nak = sda;
        bit_cnt++;
    endtask

    task automatic on_fall();
        if (bit_cnt == 8)
        begin
            if (sending)
                pull = 1'b0;    // let the master answer
            else
                take_byte();
        end
        else if (bit_cnt == 9)
        begin
            bit_cnt  = 0;
            byte_idx = byte_idx + 1;
            pull     = 1'b0;
            if ((sending && master_nak) || (!sending && !acked))
            begin
                active  = 1'b0;     // sit out until the next start
                sending = 1'b0;
            end
            else if (sending || (byte_idx == 1 && ctrl.f.rnw))
            begin
                sending = 1'b1;
                txd     = mem[ptr];
                ptr     = ptr + 11'd1;
                pull    = ~txd[7];
            end
        end
        else if (sending && bit_cnt > 0)
            pull = ~txd[7 - bit_cnt];
    endtask

    always @(scl or sda)
    begin
        if (scl === 1'b1 && scl_q === 1'b1 && sda_q === 1'b1 && sda === 1'b0)
        begin
            active   = 1'b1;    // start or repeated start
            sending  = 1'b0;
            bit_cnt  = 0;
            byte_idx = 0;
            pull     = 1'b0;
        end
        else if (scl === 1'b1 && scl_q === 1'b1 && sda_q === 1'b0 && sda === 1'b1)
        begin
            active  = 1'b0;     // stop
            sending = 1'b0;
            pull    = 1'b0;
        end
        else if (active && scl_q === 1'b0 && scl === 1'b1)
            on_rise();
        else if (active && scl_q === 1'b1 && scl === 1'b0)
            on_fall();
        scl_q = scl;
        sda_q = sda;
    end

endmodule

/* eeprom_sequencer.sv */
module eeprom_sequencer import eeprom_host_pkg::*, eeprom_bus_pkg::*;
#(
    parameter int SCL_DIV = 1
)
(
    input  logic       CLK,
    input  logic       RESET,
    input  host_req_t  req,
    input  logic [7:0] wdata,
    output host_rsp_t  rsp,
    output logic       scl,
    output bit_phase_t phase,
    output logic       cond_go,
    output logic       cond_stop,
    input  logic       cond_done,
    input  logic       cond_pull,
    output logic       tx_go,
    output ctrl_byte_u tx_byte,
    input  logic       tx_done,
    input  logic       tx_nak,
    input  logic       tx_pull,
    output logic       rx_go,
    input  logic       rx_done,
    input  logic [7:0] rx_byte,
    input  logic       rx_pull,
    output logic       sda_pull
);

    localparam int DIV_W = (SCL_DIV > 1) ? $clog2(SCL_DIV) : 1;

    seq_state_t       state;
    seq_state_t       state_nxt;
    logic [DIV_W-1:0] div_cnt;
    logic [1:0]       ph;
    logic             run;
    logic             is_rd;
    logic [10:0]      addr_q;
    logic [7:0]       wdata_q;
    logic [7:0]       rdata_q;
    logic             nak_q;

    assign run = !(state inside {idle, ready, done});

    assign phase.tick  = run && (div_cnt == DIV_W'(SCL_DIV - 1));
    assign phase.phase = ph;

    // scl stays high through the last phase of a stop so the bus ends idle
    assign scl = !run || (ph == 2'd1) || (ph == 2'd2) || ((state == stop) && (ph == 2'd3));

    assign sda_pull = cond_pull | tx_pull | rx_pull;

    assign rsp.ack   = (state == done);
    assign rsp.nak   = (state == done) && nak_q;
    assign rsp.rdata = rdata_q;

    // phase counter, parked at phase 0 outside a transfer
    always_ff @(posedge CLK)
    begin
        if (RESET || !run)
        begin
            div_cnt <= '0;
            ph      <= 2'd0;
        end
        else if (phase.tick)
        begin
            div_cnt <= '0;
            ph      <= ph + 2'd1;
        end
        else
            div_cnt <= div_cnt + DIV_W'(1);
    end

    // go strobes land on the step into phase 0
    always_comb
    begin
        state_nxt          = state;
        cond_go            = 1'b0;
        cond_stop          = 1'b0;
        tx_go              = 1'b0;
        rx_go              = 1'b0;
        tx_byte.f.dev_code = DEV_CODE;
        tx_byte.f.block    = addr_q[10:8];
        tx_byte.f.rnw      = 1'b0;
        case (state)
            idle:
                if (req.wr || req.rd)
                    state_nxt = ready;
            ready:
            begin
                cond_go   = 1'b1;
                state_nxt = wr_start;
            end
            wr_start:
                if (cond_done)
                begin
                    tx_go     = 1'b1;
                    state_nxt = ctrl_wr;
                end
            ctrl_wr:
                if (tx_done && tx_nak)
                begin
                    cond_go   = 1'b1;
                    cond_stop = 1'b1;
                    state_nxt = stop;
                end
                else if (tx_done)
                begin
                    tx_byte.raw = addr_q[7:0];
                    tx_go       = 1'b1;
                    state_nxt   = addr_wr;
                end
            addr_wr:
                if (tx_done && tx_nak)
                begin
                    cond_go   = 1'b1;
                    cond_stop = 1'b1;
                    state_nxt = stop;
                end
                else if (tx_done && is_rd)
                begin
                    cond_go   = 1'b1;  // repeated start
                    state_nxt = rd_start;
                end
                else if (tx_done)
                begin
                    tx_byte.raw = wdata_q;
                    tx_go       = 1'b1;
                    state_nxt   = data_wr;
                end
            data_wr:
                if (tx_done)
                begin
                    cond_go   = 1'b1;
                    cond_stop = 1'b1;
                    state_nxt = stop;
                end
            rd_start:
                if (cond_done)
                begin
                    tx_byte.f.rnw = 1'b1;
                    tx_go         = 1'b1;
                    state_nxt     = ctrl_rd;
                end
            ctrl_rd:
                if (tx_done && tx_nak)
                begin
                    cond_go   = 1'b1;
                    cond_stop = 1'b1;
                    state_nxt = stop;
                end
                else if (tx_done)
                begin
                    rx_go     = 1'b1;
                    state_nxt = data_rd;
                end
            data_rd:
                if (rx_done)
                begin
                    cond_go   = 1'b1;
                    cond_stop = 1'b1;
                    state_nxt = stop;
                end
            stop:
                if (cond_done)
                    state_nxt = done;
            default:
                state_nxt = idle;  // done
        endcase
    end

    always_ff @(posedge CLK)
    begin
        if (RESET)
        begin
            state <= idle;
            nak_q <= 1'b0;
        end
        else
        begin
            state <= state_nxt;
            if (state == ready)
                nak_q <= 1'b0;
            else if (tx_done && tx_nak)
                nak_q <= 1'b1;
        end
    end

    always_ff @(posedge CLK)
    begin
        if (state == idle)
        begin
            is_rd   <= !req.wr;  // write wins
            addr_q  <= req.addr;
            wdata_q <= wdata;
        end
        if (rx_done)
            rdata_q <= rx_byte;
    end

    a_ack_pulse: assert property (@(posedge CLK) disable iff (RESET)
        rsp.ack |=> !rsp.ack);

    a_one_go: assert property (@(posedge CLK) disable iff (RESET)
        $onehot0({cond_go, tx_go, rx_go}));

endmodule

/* eeprom_wr.sv */
module eeprom_wr import eeprom_host_pkg::*, eeprom_bus_pkg::*;
#(
    parameter int SCL_DIV = 1
)
(
    input  logic       CLK,
    input  logic       RESET,
    input  host_req_t  req,
    input  logic [7:0] wdata,
    output host_rsp_t  rsp,
    output logic       SCL,
    inout  wire        SDA
);

    bit_phase_t phase;
    logic       cond_go;
    logic       cond_stop;
    logic       cond_done;
    logic       cond_pull;
    logic       tx_go;
    ctrl_byte_u tx_byte;
    logic       tx_done;
    logic       tx_nak;
    logic       tx_pull;
    logic       rx_go;
    logic       rx_done;
    logic [7:0] rx_byte;
    logic       rx_pull;
    logic       sda_pull;
    logic       sda_in;

    // open drain with the pull-up on the board
    assign SDA    = sda_pull ? 1'b0 : 1'bz;
    assign sda_in = SDA;

    eeprom_sequencer #(
        .SCL_DIV (SCL_DIV)
    ) u_sequencer (
        .CLK       (CLK),
        .RESET     (RESET),
        .req       (req),
        .wdata     (wdata),
        .rsp       (rsp),
        .scl       (SCL),
        .phase     (phase),
        .cond_go   (cond_go),
        .cond_stop (cond_stop),
        .cond_done (cond_done),
        .cond_pull (cond_pull),
        .tx_go     (tx_go),
        .tx_byte   (tx_byte),
        .tx_done   (tx_done),
        .tx_nak    (tx_nak),
        .tx_pull   (tx_pull),
        .rx_go     (rx_go),
        .rx_done   (rx_done),
        .rx_byte   (rx_byte),
        .rx_pull   (rx_pull),
        .sda_pull  (sda_pull)
    );

    bus_cond_gen u_cond (
        .CLK       (CLK),
        .RESET     (RESET),
        .phase     (phase),
        .cond_go   (cond_go),
        .cond_stop (cond_stop),
        .cond_done (cond_done),
        .cond_pull (cond_pull)
    );

    byte_tx u_tx (
        .CLK     (CLK),
        .RESET   (RESET),
        .phase   (phase),
        .tx_go   (tx_go),
        .tx_byte (tx_byte),
        .sda_in  (sda_in),
        .tx_done (tx_done),
        .tx_nak  (tx_nak),
        .tx_pull (tx_pull)
    );

    byte_rx u_rx (
        .CLK     (CLK),
        .RESET   (RESET),
        .phase   (phase),
        .rx_go   (rx_go),
        .sda_in  (sda_in),
        .rx_done (rx_done),
        .rx_byte (rx_byte),
        .rx_pull (rx_pull)
    );

endmodule

/* tb.f */
eeprom_host_pkg.sv
eeprom_bus_pkg.sv
bus_cond_gen.sv
byte_tx.sv
byte_rx.sv
eeprom_sequencer.sv
eeprom_wr.sv
eeprom_model.sv
tb_eeprom_wr.sv

/* tb_eeprom_wr.sv */
module tb_eeprom_wr import eeprom_host_pkg::*;
();

    timeunit 1ns;
    timeprecision 1ps;

    localparam int SCL_DIV    = 2;
    localparam int SLOT_CYC   = 4 * SCL_DIV;
    localparam int ACK_LIMIT  = 39 * SLOT_CYC + 8;   // longest transaction plus overhead
    localparam int TIMEOUT_NS = 150 * 39 * SLOT_CYC * 100;

    logic        CLK;
    logic        RESET;
    host_req_t   req;
    logic [7:0]  wdata;
    host_rsp_t   rsp;
    logic        scl;
    wire         sda;
    logic        absent;
    int          errors = 0;
    logic [31:0] rng = 32'd6;

    pullup (sda);

    eeprom_wr #(
        .SCL_DIV (SCL_DIV)
    ) u_eeprom_wr (
        .CLK   (CLK),
        .RESET (RESET),
        .req   (req),
        .wdata (wdata),
        .rsp   (rsp),
        .SCL   (scl),
        .SDA   (sda)
    );

    eeprom_model u_model (
        .scl    (scl),
        .sda    (sda),
        .absent (absent)
    );

    initial
    begin
        CLK = 1'b0;
        forever #50 CLK = ~CLK;
    end

    function automatic logic [31:0] xorshift(logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    function automatic logic [7:0] rand_byte();
        rng = xorshift(rng);
        return rng[7:0];
    endfunction

    function automatic host_rsp_t expect_rsp(logic nak);
        host_rsp_t r;
        r     = '0;
        r.ack = 1'b1;
        r.nak = nak;
        return r;
    endfunction

    // rdata is checked on its own with check_byte
    task automatic check_rsp(host_rsp_t got, host_rsp_t exp, string what);
        if ({got.ack, got.nak} !== {exp.ack, exp.nak})
        begin
            $display("ERROR %0t: %s ack/nak %b%b expected %b%b", $time, what,
                     got.ack, got.nak, exp.ack, exp.nak);
            errors++;
        end
    endtask

    task automatic check_byte(logic [7:0] got, logic [7:0] exp, string what);
        if (got !== exp)
        begin
            $display("ERROR %0t: %s got %h expected %h", $time, what, got, exp);
            errors++;
        end
    endtask

    task automatic check_bus(logic exp_scl, logic exp_sda, string what);
        if ({scl, sda} !== {exp_scl, exp_sda})
        begin
            $display("ERROR %0t: %s scl/sda %b%b expected %b%b", $time, what,
                     scl, sda, exp_scl, exp_sda);
            errors++;
        end
    endtask

    task automatic check_idle(string what);
        host_rsp_t quiet;
        quiet = '0;
        @(negedge CLK);
        check_bus(1'b1, 1'b1, what);
        check_rsp(rsp, quiet, what);
    endtask

    task automatic raise_req(logic wr, logic rd, logic [10:0] addr, logic [7:0] data);
        @(posedge CLK);
        #5;
        req.wr   = wr;
        req.rd   = rd;
        req.addr = addr;
        wdata    = data;
    endtask

    task automatic wait_ack(output host_rsp_t seen);
        int n;
        n = 0;
        while (rsp.ack !== 1'b1 && n < ACK_LIMIT)
        begin
            @(negedge CLK);
            n++;
        end
        if (rsp.ack !== 1'b1)
        begin
            $display("the controller gave no ack within %0d cycles", ACK_LIMIT);
            errors++;
        end
        seen = rsp;
    endtask

    task automatic drop_req();
        @(posedge CLK);
        #5;
        req   = '0;
        wdata = '0;
    endtask

    task automatic xfer(logic wr, logic rd, logic [10:0] addr, logic [7:0] data,
                        output host_rsp_t seen);
        raise_req(wr, rd, addr, data);
        wait_ack(seen);
        drop_req();
        check_idle("bus idle between transactions");
    endtask

    task automatic test_reset_idle();
        check_idle("after reset");
    endtask

    task automatic test_write_read();
        host_rsp_t  seen;
        logic [7:0] data;
        data = rand_byte();
        xfer(1'b1, 1'b0, 11'h123, data, seen);
        check_rsp(seen, expect_rsp(1'b0), "write 123");
        xfer(1'b0, 1'b1, 11'h123, 8'h00, seen);
        check_rsp(seen, expect_rsp(1'b0), "read 123");
        check_byte(seen.rdata, data, "read back 123");
    endtask

    task automatic test_blocks();
        logic [10:0] addr [16];
        logic [7:0]  data [16];
        logic [7:0]  lo;
        logic [7:0]  r;
        host_rsp_t   seen;
        lo = rand_byte();   // one low byte shared by all blocks
        for (int i = 0; i < 16; i++)
        begin
            addr[i] = {3'(i), lo[7:1], i[3]};   // every block twice, never the same address
            r       = rand_byte();
            data[i] = {r[7:4], 4'(i)};
            xfer(1'b1, 1'b0, addr[i], data[i], seen);
            check_rsp(seen, expect_rsp(1'b0), $sformatf("block write %0d", i));
        end
        for (int i = 0; i < 16; i++)
        begin
            xfer(1'b0, 1'b1, addr[i], 8'h00, seen);
            check_rsp(seen, expect_rsp(1'b0), $sformatf("block read %0d", i));
            check_byte(seen.rdata, data[i], $sformatf("block data %0d", i));
        end
    endtask

    task automatic test_missing();
        host_rsp_t  seen;
        logic [7:0] keep;
        keep = rand_byte();
        xfer(1'b1, 1'b0, 11'h5a7, keep, seen);
        check_rsp(seen, expect_rsp(1'b0), "write before removal");
        absent = 1'b1;
        xfer(1'b1, 1'b0, 11'h5a7, ~keep, seen);
        check_rsp(seen, expect_rsp(1'b1), "write to missing device");
        xfer(1'b0, 1'b1, 11'h5a7, 8'h00, seen);
        check_rsp(seen, expect_rsp(1'b1), "read from missing device");
        absent = 1'b0;
        xfer(1'b0, 1'b1, 11'h5a7, 8'h00, seen);
        check_rsp(seen, expect_rsp(1'b0), "read after return");
        check_byte(seen.rdata, keep, "value kept while missing");
    endtask

    task automatic test_priority();
        host_rsp_t  seen;
        logic [7:0] da;
        logic [7:0] db;
        da = rand_byte();
        db = ~da;
        xfer(1'b1, 1'b0, 11'h631, db, seen);
        raise_req(1'b1, 1'b1, 11'h2c4, da);
        repeat (20) @(posedge CLK);   // well inside the write
        #5;
        req.wr   = 1'b0;
        req.addr = 11'h631;
        wdata    = da ^ 8'h3c;
        wait_ack(seen);
        drop_req();
        check_idle("idle after wr and rd together");
        check_rsp(seen, expect_rsp(1'b0), "wr and rd together");
        xfer(1'b0, 1'b1, 11'h2c4, 8'h00, seen);
        check_byte(seen.rdata, da, "write won over read");
        xfer(1'b0, 1'b1, 11'h631, 8'h00, seen);
        check_byte(seen.rdata, db, "busy request change ignored");
    endtask

    initial
    begin
        RESET  = 1'b1;
        req    = '0;
        wdata  = '0;
        absent = 1'b0;
        repeat (2) @(posedge CLK);
        #5;
        RESET = 1'b0;
        test_reset_idle();
        test_write_read();
        test_blocks();
        test_missing();
        test_priority();
        $display("all tests run, %0d errors", errors);
        if (errors == 0)
            $display("Test passed");
        else
            $display("Test failed");
        $finish;
    end

    initial
    begin
        #(TIMEOUT_NS);
        $display("watchdog expired with the sequencer in state %s, %0d errors so far",
                 u_eeprom_wr.u_sequencer.state.name(), errors);
        $display("Test failed");
        $finish;
    end

endmodule
